/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build ooo_tb with Verilator and run it"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert --top-module ooo_tb -f vlog.f -o ooo_tb
	@out="$$(./obj_dir/ooo_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* hw/alu_cdb.sv */
`timescale 1ns/100ps

module alu_cdb import ooo_pkg::*; (
    input  logic clock,
    input  logic arst_n,
    issue_if.dst iss,
    cdb_if.src   cdb
);

    data_t result;

    always_comb begin
        case (iss.op)
            OP_LI:   result = iss.op1;
            OP_ADD:  result = iss.op1 + iss.op2;
            OP_SUB:  result = iss.op1 - iss.op2;
            OP_AND:  result = iss.op1 & iss.op2;
            OP_OR:   result = iss.op1 | iss.op2;
            OP_XOR:  result = iss.op1 ^ iss.op2;
            OP_SLL:  result = iss.op1 << iss.op2[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= iss.valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb.prn   <= iss.prn;
        cdb.robn  <= iss.robn;
        cdb.value <= result;
    end

endmodule

/* hw/ooo.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module ooo import ooo_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              disp_valid,
    input  opcode_e           disp_op,
    input  arn_t              disp_rd,
    input  arn_t              disp_rs1,
    input  arn_t              disp_rs2,
    input  logic [`IMM_W-1:0] disp_imm,
    output logic              stall,
    output logic              commit_valid,
    output arn_t              commit_rd,
    output data_t             commit_value
);

    cdb_if    cdb ();
    rename_if ren ();
    issue_if  iss ();

    prn_t [1:0]  prf_rd_prn;
    data_t [1:0] prf_rd_value;
    logic [1:0]  prf_rd_ready;
    prn_t        prf_ct_prn;
    data_t       prf_ct_value;

    logic        rs_wr;
    rs_entry_t   rs_entry;
    logic        rs_full;

    logic        rob_wr;
    rob_entry_t  rob_entry;
    robn_t       rob_tail;
    logic        rob_full;
    logic        rob_head_valid;
    rob_entry_t  rob_head;
    logic        rob_pop;

    ooo_ctrl ctrl_i (
        .clock(clock), .arst_n(arst_n),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_rd(disp_rd),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .stall(stall), .ren(ren),
        .prf_rd_prn(prf_rd_prn), .prf_rd_value(prf_rd_value), .prf_rd_ready(prf_rd_ready),
        .cdb(cdb),
        .rs_wr(rs_wr), .rs_entry(rs_entry), .rs_full(rs_full),
        .rob_wr(rob_wr), .rob_entry(rob_entry), .rob_tail(rob_tail), .rob_full(rob_full),
        .rob_head_valid(rob_head_valid), .rob_head(rob_head), .rob_pop(rob_pop),
        .prf_ct_prn(prf_ct_prn), .prf_ct_value(prf_ct_value),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    rat rat_i (.clock(clock), .arst_n(arst_n), .ren(ren));

    // destination is allocated at rename
    prf prf_i (
        .clock(clock), .arst_n(arst_n),
        .rd_prn(prf_rd_prn), .rd_value(prf_rd_value), .rd_ready(prf_rd_ready),
        .ct_prn(prf_ct_prn), .ct_value(prf_ct_value),
        .alloc_valid(ren.req), .alloc_prn(ren.dest_prn),
        .cdb(cdb)
    );

    rs rs_i (
        .clock(clock), .arst_n(arst_n), .wr(rs_wr), .entry(rs_entry),
        .cdb(cdb), .iss(iss), .full(rs_full)
    );

    alu_cdb alu_i (.clock(clock), .arst_n(arst_n), .iss(iss), .cdb(cdb));

    rob rob_i (
        .clock(clock), .arst_n(arst_n), .wr(rob_wr), .entry(rob_entry),
        .tail(rob_tail), .full(rob_full), .cdb(cdb),
        .head_valid(rob_head_valid), .head(rob_head), .pop(rob_pop)
    );

endmodule

/* hw/ooo_ctrl.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module ooo_ctrl import ooo_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              disp_valid,
    input  opcode_e           disp_op,
    input  arn_t              disp_rd,
    input  arn_t              disp_rs1,
    input  arn_t              disp_rs2,
    input  logic [`IMM_W-1:0] disp_imm,
    output logic              stall,
    rename_if.ctrl            ren,
    output prn_t [1:0]        prf_rd_prn,
    input  data_t [1:0]       prf_rd_value,
    input  logic [1:0]        prf_rd_ready,
    cdb_if.dst                cdb,
    output logic              rs_wr,
    output rs_entry_t         rs_entry,
    input  logic              rs_full,
    output logic              rob_wr,
    output rob_entry_t        rob_entry,
    input  robn_t             rob_tail,
    input  logic              rob_full,
    input  logic              rob_head_valid,
    input  rob_entry_t        rob_head,
    output logic              rob_pop,
    output prn_t              prf_ct_prn,
    input  data_t             prf_ct_value,
    output logic              commit_valid,
    output arn_t              commit_rd,
    output data_t             commit_value
);

    logic        accept;
    logic [1:0]  op_ready;
    data_t [1:0] op_value;

    // structural hazard, independent of disp_valid
    assign stall  = rs_full | rob_full | ren.free_empty;
    assign accept = disp_valid & ~stall;

    assign ren.req = accept;
    assign ren.rd  = disp_rd;
    assign ren.rs1 = disp_rs1;
    assign ren.rs2 = disp_rs2;

    assign prf_rd_prn[0] = ren.op1_prn;
    assign prf_rd_prn[1] = ren.op2_prn;

    // prf value, else same-cycle cdb bypass, else keep the tag
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (prf_rd_ready[k]) begin
                op_ready[k] = 1'b1;
                op_value[k] = prf_rd_value[k];
            end else if (cdb.valid && cdb.prn == prf_rd_prn[k]) begin
                op_ready[k] = 1'b1;
                op_value[k] = cdb.value;
            end else begin
                op_ready[k] = 1'b0;
                op_value[k] = data_t'(prf_rd_prn[k]);
            end
        end
    end

    always_comb begin
        rs_entry.valid     = 1'b1;
        rs_entry.op        = disp_op;
        rs_entry.op1_ready = op_ready[0];
        rs_entry.op1       = op_value[0];
        rs_entry.op2_ready = op_ready[1];
        rs_entry.op2       = op_value[1];
        // li ignores its sources
        if (disp_op == OP_LI) begin
            rs_entry.op1_ready = 1'b1;
            rs_entry.op1       = {{(`XLEN-`IMM_W){disp_imm[`IMM_W-1]}}, disp_imm};
            rs_entry.op2_ready = 1'b1;
            rs_entry.op2       = '0;
        end
        rs_entry.dest_prn = ren.dest_prn;
        rs_entry.robn     = rob_tail;
    end

    assign rs_wr  = accept;
    assign rob_wr = accept;
    assign rob_entry = '{state: ENT_WAIT, dest_arn: disp_rd,
                         dest_prn: ren.dest_prn, old_prn: ren.old_prn};

    // commit
    assign rob_pop        = rob_head_valid && rob_head.state == ENT_DONE;
    assign prf_ct_prn     = rob_head.dest_prn;
    assign ren.free_valid = rob_pop && rob_head.dest_arn != '0;
    assign ren.free_prn   = rob_head.old_prn;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= rob_pop;
        end
    end

    always_ff @(posedge clock) begin
        if (rob_pop) begin
            commit_rd    <= rob_head.dest_arn;
            commit_value <= prf_ct_value;
        end
    end

endmodule

/* hw/ooo_if.sv */
`timescale 1ns/100ps

// result broadcast, one cycle, no back-pressure
interface cdb_if import ooo_pkg::*; ();
    logic  valid;
    prn_t  prn;
    robn_t robn;
    data_t value;

    modport src (output valid, prn, robn, value);
    modport dst (input valid, prn, robn, value);
endinterface

interface rename_if import ooo_pkg::*; ();
    logic req;
    arn_t rd;
    arn_t rs1;
    arn_t rs2;
    prn_t dest_prn;
    prn_t old_prn;
    prn_t op1_prn;
    prn_t op2_prn;
    logic free_empty;
    logic free_valid;
    prn_t free_prn;

    modport ctrl (output req, rd, rs1, rs2, free_valid, free_prn,
                  input dest_prn, old_prn, op1_prn, op2_prn, free_empty);
    modport tbl (input req, rd, rs1, rs2, free_valid, free_prn,
                 output dest_prn, old_prn, op1_prn, op2_prn, free_empty);
endinterface

interface issue_if import ooo_pkg::*; ();
    logic    valid;
    opcode_e op;
    data_t   op1;
    data_t   op2;
    prn_t    prn;
    robn_t   robn;

    modport src (output valid, op, op1, op2, prn, robn);
    modport dst (input valid, op, op1, op2, prn, robn);
endinterface

/* hw/ooo_pkg.sv */
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]               data_t;
    typedef logic [$clog2(`ARCH_REGS)-1:0]  arn_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0]  prn_t;
    typedef logic [$clog2(`ROB_SZ)-1:0]     robn_t;

    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL
    } opcode_e;

    // ENT_FREE must stay the all-zero encoding
    typedef enum logic [1:0] {
        ENT_FREE,
        ENT_WAIT,
        ENT_DONE
    } rob_state_e;

    // op1/op2 hold a prn in the low bits until ready
    typedef struct packed {
        logic    valid;
        opcode_e op;
        logic    op1_ready;
        data_t   op1;
        logic    op2_ready;
        data_t   op2;
        prn_t    dest_prn;
        robn_t   robn;
    } rs_entry_t;

    typedef struct packed {
        rob_state_e state;
        arn_t       dest_arn;
        prn_t       dest_prn;
        prn_t       old_prn;
    } rob_entry_t;

endpackage

/* hw/ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath width
`define XLEN 32

// register counts
`define ARCH_REGS 8
`define PHYS_REGS 16

// queue depths, both powers of two
`define ROB_SZ 8
`define RS_SZ 4

// dispatch immediate, sign extended to XLEN
`define IMM_W 16

`endif

/* hw/prf.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module prf import ooo_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  prn_t [1:0]  rd_prn,
    output data_t [1:0] rd_value,
    output logic [1:0]  rd_ready,
    input  prn_t        ct_prn,
    output data_t       ct_value,
    input  logic        alloc_valid,
    input  prn_t        alloc_prn,
    cdb_if.dst          cdb
);

    data_t [`PHYS_REGS-1:0] values;
    logic  [`PHYS_REGS-1:0] ready;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            rd_value[k] = values[rd_prn[k]];
            rd_ready[k] = ready[rd_prn[k]];
        end
    end

    assign ct_value = values[ct_prn];

    // p0 is hardwired ready and zero
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            values <= '0;
            ready  <= '1;
        end else begin
            if (cdb.valid && cdb.prn != '0) begin
                values[cdb.prn] <= cdb.value;
                ready[cdb.prn]  <= 1'b1;
            end
            if (alloc_valid && alloc_prn != '0) begin
                ready[alloc_prn] <= 1'b0;
            end
        end
    end

endmodule

/* hw/rat.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module rat import ooo_pkg::*; (
    input  logic  clock,
    input  logic  arst_n,
    rename_if.tbl ren
);

    localparam int FREE_INIT = `PHYS_REGS - `ARCH_REGS;

    typedef logic [$clog2(`PHYS_REGS):0] cnt_t;

    prn_t [`ARCH_REGS-1:0] map;
    prn_t [`PHYS_REGS-1:0] free_list;
    prn_t                  fl_head;
    prn_t                  fl_tail;
    cnt_t                  fl_count;
    logic                  take;

    // r0 never takes a register
    assign take = ren.req && ren.rd != '0;

    assign ren.op1_prn    = map[ren.rs1];
    assign ren.op2_prn    = map[ren.rs2];
    assign ren.old_prn    = map[ren.rd];
    assign ren.dest_prn   = (ren.rd != '0) ? free_list[fl_head] : '0;
    assign ren.free_empty = fl_count == '0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= prn_t'(i);
            end
            // upper half of the prf starts free
            for (int i = 0; i < `PHYS_REGS; i++) begin
                free_list[i] <= (i < FREE_INIT) ? prn_t'(i + `ARCH_REGS) : '0;
            end
            fl_head  <= '0;
            fl_tail  <= prn_t'(FREE_INIT);
            fl_count <= cnt_t'(FREE_INIT);
        end else begin
            if (take) begin
                map[ren.rd] <= free_list[fl_head];
                fl_head     <= fl_head + 1'b1;
            end
            if (ren.free_valid) begin
                free_list[fl_tail] <= ren.free_prn;
                fl_tail            <= fl_tail + 1'b1;
            end
            case ({take, ren.free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

endmodule

/* hw/rob.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module rob import ooo_pkg::*; (
    input  logic       clock,
    input  logic       arst_n,
    input  logic       wr,
    input  rob_entry_t entry,
    output robn_t      tail,
    output logic       full,
    cdb_if.dst         cdb,
    output logic       head_valid,
    output rob_entry_t head,
    input  logic       pop
);

    rob_entry_t [`ROB_SZ-1:0]  entries;
    robn_t                     head_ptr;
    logic [$clog2(`ROB_SZ):0]  count;

    assign full       = count == `ROB_SZ;
    assign head_valid = count != '0;
    assign head       = entries[head_ptr];

    // pointers wrap naturally
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entries  <= '0;
            head_ptr <= '0;
            tail     <= '0;
            count    <= '0;
        end else begin
            if (cdb.valid) begin
                entries[cdb.robn].state <= ENT_DONE;
            end
            if (wr) begin
                entries[tail] <= entry;
                tail          <= tail + 1'b1;
            end
            if (pop) begin
                entries[head_ptr].state <= ENT_FREE;
                head_ptr                <= head_ptr + 1'b1;
            end
            case ({wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/rs.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module rs import ooo_pkg::*; (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      wr,
    input  rs_entry_t entry,
    cdb_if.dst        cdb,
    issue_if.src      iss,
    output logic      full
);

    // entries are kept compacted, index 0 is the oldest
    rs_entry_t [`RS_SZ-1:0]    entries;
    rs_entry_t [`RS_SZ-1:0]    woken;
    rs_entry_t [`RS_SZ-1:0]    nxt;
    logic [$clog2(`RS_SZ)-1:0] sel;
    logic                      sel_valid;
    logic                      placed;

    // tag match against the cdb
    always_comb begin
        woken = entries;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (cdb.valid && !woken[i].op1_ready && prn_t'(woken[i].op1) == cdb.prn) begin
                woken[i].op1       = cdb.value;
                woken[i].op1_ready = 1'b1;
            end
            if (cdb.valid && !woken[i].op2_ready && prn_t'(woken[i].op2) == cdb.prn) begin
                woken[i].op2       = cdb.value;
                woken[i].op2_ready = 1'b1;
            end
        end
    end

    // lowest ready index wins
    always_comb begin
        sel       = '0;
        sel_valid = 1'b0;
        for (int i = `RS_SZ-1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].op1_ready && entries[i].op2_ready) begin
                sel       = i[$clog2(`RS_SZ)-1:0];
                sel_valid = 1'b1;
            end
        end
    end

    assign iss.valid = sel_valid;
    assign iss.op    = entries[sel].op;
    assign iss.op1   = entries[sel].op1;
    assign iss.op2   = entries[sel].op2;
    assign iss.prn   = entries[sel].dest_prn;
    assign iss.robn  = entries[sel].robn;

    // close the gap left by the issued entry, then append
    always_comb begin
        nxt    = woken;
        placed = 1'b0;
        if (sel_valid) begin
            for (int i = 0; i < `RS_SZ-1; i++) begin
                if (i >= int'(sel)) begin
                    nxt[i] = woken[i+1];
                end
            end
            nxt[`RS_SZ-1] = '0;
        end
        if (wr) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                if (!placed && !nxt[i].valid) begin
                    nxt[i] = entry;
                    placed = 1'b1;
                end
            end
        end
    end

    assign full = entries[`RS_SZ-1].valid;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entries <= '0;
        end else begin
            entries <= nxt;
        end
    end

endmodule

/* test/ooo_checker.sv */
`timescale 1ns/100ps

module ooo_checker (
    input logic clock,
    input logic arst_n,
    input logic disp_valid,
    input logic stall,
    input logic commit_valid
);

    logic accepted_any;
    int   fails = 0;

    // set by the first instruction that gets in
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            accepted_any <= 1'b0;
        end else if (disp_valid && !stall) begin
            accepted_any <= 1'b1;
        end
    end

    a_outputs_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown({commit_valid, stall}))
    else begin
        fails++;
        $error("commit_valid or stall is unknown");
    end

    a_quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !commit_valid)
    else begin
        fails++;
        $error("commit_valid high during reset");
    end

    // nothing can retire before something was dispatched
    a_commit_after_accept: assert property (@(posedge clock) disable iff (!arst_n)
        commit_valid |-> accepted_any)
    else begin
        fails++;
        $error("commit_valid high with no prior acceptance");
    end

endmodule

/* test/ooo_tb.sv */
`timescale 1ns/100ps
`include "ooo_settings.svh"

module ooo_tb import ooo_pkg::*; ();

    logic              clock;
    logic              arst_n;
    logic              disp_valid;
    opcode_e           disp_op;
    arn_t              disp_rd;
    arn_t              disp_rs1;
    arn_t              disp_rs2;
    logic [`IMM_W-1:0] disp_imm;
    logic              stall;
    logic              commit_valid;
    arn_t              commit_rd;
    data_t             commit_value;

    logic [31:0] rng_state;
    data_t       model_regs [`ARCH_REGS];
    arn_t        exp_rd [$];
    data_t       exp_value [$];
    logic        last_accepted;
    int          errors;
    int          checks;
    int          accepted;
    int          committed;
    int          stall_cycles;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;

    ooo dut_i (
        .clock(clock), .arst_n(arst_n),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_rd(disp_rd),
        .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .stall(stall), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_value(commit_value)
    );

    bind ooo ooo_checker checker_i (
        .clock(clock), .arst_n(arst_n), .disp_valid(disp_valid),
        .stall(stall), .commit_valid(commit_valid)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // in-order reference with a sign-extended immediate
    function automatic data_t model_result(input opcode_e op, input data_t a, input data_t b,
                                           input logic [`IMM_W-1:0] imm);
        case (op)
            OP_LI:   return data_t'($signed(imm));
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic compare(input string name, input data_t expected, input data_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_commit();
        if (commit_valid) begin
            committed++;
            if (exp_rd.size() == 0) begin
                errors++;
                $display("commit seen at %0d ns with no instruction outstanding", $time);
            end else begin
                compare("commit_rd", data_t'(exp_rd.pop_front()), data_t'(commit_rd));
                compare("commit_value", exp_value.pop_front(), commit_value);
            end
        end
    endtask

    // a full buffer must stall, a nearly empty core must not
    task automatic check_stall();
        if (exp_rd.size() >= `ROB_SZ) begin
            compare("stall", data_t'(1'b1), data_t'(stall));
        end else if (exp_rd.size() < `RS_SZ) begin
            compare("stall", '0, data_t'(stall));
        end
    endtask

    task automatic record_accept();
        data_t result;
        last_accepted = disp_valid && !stall;
        if (last_accepted) begin
            result = model_result(disp_op, model_regs[disp_rs1], model_regs[disp_rs2], disp_imm);
            exp_rd.push_back(disp_rd);
            if (disp_rd == '0) begin
                // r0 retires as the zero register
                exp_value.push_back('0);
            end else begin
                exp_value.push_back(result);
                model_regs[disp_rd] = result;
            end
            accepted++;
        end else if (disp_valid) begin
            stall_cycles++;
        end
    endtask

    // sample mid-cycle, then drive 1 ns after the edge
    task automatic cycle();
        @(negedge clock);
        check_commit();
        check_stall();
        record_accept();
        @(posedge clock);
        #1;
    endtask

    task automatic drive_random(input logic [3:0] duty);
        logic [31:0] r;
        r = next_random();
        disp_valid = r[31:28] < duty;
        disp_op    = opcode_e'(r[2:0] % 3'd7);
        disp_rd    = r[5:3];
        disp_rs1   = r[8:6];
        disp_rs2   = r[11:9];
        disp_imm   = r[12 +: `IMM_W];
    endtask

    // hold one instruction until it gets in
    task automatic issue(input opcode_e op, input arn_t rd, input arn_t rs1, input arn_t rs2,
                         input logic [`IMM_W-1:0] imm);
        int n;
        n = 0;
        disp_valid = 1'b1;
        disp_op    = op;
        disp_rd    = rd;
        disp_rs1   = rs1;
        disp_rs2   = rs2;
        disp_imm   = imm;
        cycle();
        while (!last_accepted && n < 100) begin
            cycle();
            n++;
        end
        if (!last_accepted) begin
            errors++;
            $display("timeout: instruction held for 100 cycles was never accepted");
        end
        disp_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        disp_valid = 1'b0;
        while (exp_rd.size() != 0 && n < 200) begin
            cycle();
            n++;
        end
        if (exp_rd.size() != 0) begin
            errors++;
            $display("timeout: %0d accepted instructions never committed", exp_rd.size());
        end
        // catch stray commits
        repeat (4) cycle();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        int          base;
        int          n;
        logic [31:0] r;
        arn_t        prev;
        rng_state         = 32'h0910_359f;
        errors            = 0;
        checks            = 0;
        accepted          = 0;
        committed         = 0;
        stall_cycles      = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        last_accepted     = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        arst_n     = 1'b0;
        disp_valid = 1'b0;
        disp_op    = OP_LI;
        disp_rd    = '0;
        disp_rs1   = '0;
        disp_rs2   = '0;
        disp_imm   = '0;
        repeat (2) @(posedge clock);
        #1;
        arst_n = 1'b1;

        compare("stall", '0, data_t'(stall));
        compare("commit_valid", '0, data_t'(commit_valid));
        for (int i = 0; i < `ARCH_REGS; i++) begin
            r = next_random();
            issue(OP_LI, arn_t'(i), '0, '0, r[`IMM_W-1:0]);
        end
        drain();
        end_test("reset and load immediates");

        r = next_random();
        issue(OP_LI, 3'd1, '0, '0, r[`IMM_W-1:0]);
        prev = 3'd1;
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            issue(opcode_e'(3'd1 + r[2:0] % 3'd6), arn_t'(i % 7 + 1), prev, r[5:3], '0);
            prev = arn_t'(i % 7 + 1);
        end
        drain();
        end_test("dependent chains");

        repeat (80) begin
            drive_random(4'd10);
            cycle();
        end
        drain();
        end_test("commit order under random traffic");

        // one long chain on r2 issues slower than dispatch
        stall_cycles = 0;
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            disp_valid = 1'b1;
            disp_op    = opcode_e'(3'd1 + r[2:0] % 3'd6);
            disp_rd    = 3'd2;
            disp_rs1   = 3'd2;
            disp_rs2   = r[5:3];
            cycle();
        end
        if (stall_cycles == 0) begin
            errors++;
            $display("stall never rose under continuous dependent dispatch");
        end
        drain();
        repeat (20) begin
            drive_random(4'd14);
            cycle();
        end
        drain();
        end_test("back-pressure");

        base = accepted;
        n = 0;
        while (accepted - base < 120 && n < 2000) begin
            drive_random(4'd12);
            cycle();
            n++;
        end
        if (accepted - base < 120) begin
            errors++;
            $display("timeout: only %0d of 120 instructions accepted", accepted - base);
        end
        r = next_random();
        issue(OP_LI, 3'd0, '0, '0, {r[`IMM_W-1:1], 1'b1});
        issue(OP_OR, 3'd4, 3'd0, 3'd0, '0);
        drain();
        end_test("register recycling and r0");

        repeat (30) begin
            drive_random(4'd12);
            cycle();
        end
        drain();
        compare("commit count", data_t'(accepted), data_t'(committed));
        end_test("drain");

        if (dut_i.checker_i.fails != 0) begin
            errors += dut_i.checker_i.fails;
            $display("%0d assertion failures in the checker", dut_i.checker_i.fails);
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d accepted, %0d committed",
                 tests_run, tests_failed, checks, errors, accepted, committed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/ooo_pkg.sv
hw/ooo_if.sv
hw/ooo_ctrl.sv
hw/rat.sv
hw/prf.sv
hw/rs.sv
hw/alu_cdb.sv
hw/rob.sv
hw/ooo.sv
test/ooo_checker.sv
test/ooo_tb.sv
